/* common/pipe_consts.svh */
// integer pipeline constants
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// widths
`define WORD_W      32
`define REG_NUM     32
`define REG_ADDR_W  5
`define SHAMT_W     5
`define IMM_W       16
`define OP_W        6
`define FN_W        6

// instruction fields
`define F_OP        31:26
`define F_RS        25:21
`define F_RT        20:16
`define F_RD        15:11
`define F_SHAMT     10:6
`define F_FUNCT     5:0
`define F_IMM       15:0

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// funct codes under OP_SPECIAL
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111

`endif

/* common/pipe_pkg.sv */
// integer pipeline types
`include "pipe_consts.svh"

package pipe_pkg;

    // data word for operands and results
    typedef logic [`WORD_W-1:0] word_t;

    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation subtype
    // variable shifts reuse the immediate shift codes,
    // decode puts the amount into reg1 either way
    typedef enum logic [3:0] {
        alu_nop  = 4'd0,
        alu_or   = 4'd1,
        alu_and  = 4'd2,
        alu_xor  = 4'd3,
        alu_nor  = 4'd4,
        alu_lui  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_add  = 4'd9,    // traps on overflow
        alu_addu = 4'd10,
        alu_sub  = 4'd11,   // traps on overflow
        alu_subu = 4'd12,
        alu_slt  = 4'd13,
        alu_sltu = 4'd14
    } alu_op_e;

    // result group picked in execute
    typedef enum logic [1:0] {
        sel_none  = 2'd0,
        sel_logic = 2'd1,
        sel_shift = 2'd2,
        sel_arith = 2'd3
    } alu_sel_e;

endpackage

/* dv/int_pipe_assertions.sv */
// write-back port assertions
`timescale 1ns/10ps

module int_pipe_assertions (
    input logic                clk,
    input logic                rst_n_i,
    input logic                wb_we_i,
    input pipe_pkg::reg_addr_t wb_addr_i,
    input pipe_pkg::word_t     wb_data_i
);

    int unsigned fail_cnt = 0;   // failed checks so far

    // reset flushes id_ex_reg
    property we_low_after_reset;
        @(posedge clk) !rst_n_i |=> !wb_we_i;
    endproperty

    property no_write_to_zero;
        @(posedge clk) disable iff (!rst_n_i) wb_we_i |-> (wb_addr_i != '0);
    endproperty

    property data_known_on_write;
        @(posedge clk) disable iff (!rst_n_i) wb_we_i |-> !$isunknown(wb_data_i);
    endproperty

    a_we_after_reset: assert property (we_low_after_reset)
        else begin
            $error("write enable high in the cycle after reset");
            fail_cnt++;
        end

    a_no_zero_write: assert property (no_write_to_zero)
        else begin
            $error("write enable high with destination register zero");
            fail_cnt++;
        end

    a_data_known: assert property (data_known_on_write)
        else begin
            $error("write data unknown while write enable is high");
            fail_cnt++;
        end

endmodule

bind int_pipe_top int_pipe_assertions u_assert (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wb_we_i   (wb_we_o),
    .wb_addr_i (wb_addr_o),
    .wb_data_i (wb_data_o)
);

/* dv/int_pipe_tb.sv */
// integer pipeline testbench
`timescale 1ns/10ps
`include "pipe_consts.svh"

module int_pipe_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RST_CYCLES     = 4;
    localparam int DRV_DLY        = 1;
    localparam int N_ENTRIES      = 45;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 4 + 20;

    logic                clk;
    logic                rst_n_i;
    pipe_pkg::word_t     inst_i;
    logic                inst_valid_i;
    logic                wb_we_o;
    pipe_pkg::reg_addr_t wb_addr_o;
    pipe_pkg::word_t     wb_data_o;

    // one row per instruction with its expected write-back
    pipe_pkg::word_t     tbl_inst [N_ENTRIES];
    logic                tbl_we   [N_ENTRIES];
    pipe_pkg::reg_addr_t tbl_addr [N_ENTRIES];
    pipe_pkg::word_t     tbl_data [N_ENTRIES];

    int     n_loaded = 0;
    int     cycles   = 0;
    integer seed     = 36701;

    int_pipe_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic pipe_pkg::word_t encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] sa,
                                                 input logic [5:0] funct);
        return {`OP_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic pipe_pkg::word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_entry(input pipe_pkg::word_t inst, input logic we,
                             input pipe_pkg::reg_addr_t addr, input pipe_pkg::word_t data);
        tbl_inst[n_loaded] = inst;
        tbl_we[n_loaded]   = we;
        tbl_addr[n_loaded] = addr;
        tbl_data[n_loaded] = data;
        n_loaded++;
    endtask

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_table();
        // immediate logic on zero-extended immediates
        add_entry(encode_i(`OP_ORI,  5'd0, 5'd1, 16'h8001), 1'b1, 5'd1, 32'h0000_8001);
        add_entry(encode_i(`OP_LUI,  5'd0, 5'd2, 16'h1234), 1'b1, 5'd2, 32'h1234_0000);
        add_entry(encode_i(`OP_XORI, 5'd2, 5'd3, 16'hFFFF), 1'b1, 5'd3, 32'h1234_FFFF);
        add_entry(encode_i(`OP_ORI,  5'd2, 5'd2, 16'h5678), 1'b1, 5'd2, 32'h1234_5678);
        add_entry(encode_i(`OP_ANDI, 5'd3, 5'd4, 16'h0F0F), 1'b1, 5'd4, 32'h0000_0F0F);
        add_entry(encode_i(`OP_LUI,  5'd0, 5'd5, 16'hF0F0), 1'b1, 5'd5, 32'hF0F0_0000);
        // register logic where each one uses the one before
        add_entry(encode_r(5'd2, 5'd5, 5'd6, 5'd0, `FN_OR),  1'b1, 5'd6, 32'hF2F4_5678);
        add_entry(encode_r(5'd6, 5'd3, 5'd7, 5'd0, `FN_AND), 1'b1, 5'd7, 32'h1234_5678);
        add_entry(encode_r(5'd7, 5'd6, 5'd8, 5'd0, `FN_XOR), 1'b1, 5'd8, 32'hE0C0_0000);
        add_entry(encode_r(5'd8, 5'd4, 5'd9, 5'd0, `FN_NOR), 1'b1, 5'd9, 32'h1F3F_F0F0);
        // shifts with the variable amount taken from rs
        add_entry(encode_r(5'd0, 5'd2, 5'd10, 5'd4, `FN_SLL),  1'b1, 5'd10, 32'h2345_6780);
        add_entry(encode_r(5'd0, 5'd8, 5'd11, 5'd8, `FN_SRL),  1'b1, 5'd11, 32'h00E0_C000);
        add_entry(encode_r(5'd0, 5'd8, 5'd12, 5'd8, `FN_SRA),  1'b1, 5'd12, 32'hFFE0_C000);
        add_entry(encode_r(5'd4, 5'd2, 5'd13, 5'd0, `FN_SLLV), 1'b1, 5'd13, 32'h2B3C_0000);
        add_entry(encode_r(5'd1, 5'd8, 5'd14, 5'd0, `FN_SRLV), 1'b1, 5'd14, 32'h7060_0000);
        add_entry(encode_r(5'd1, 5'd8, 5'd15, 5'd0, `FN_SRAV), 1'b1, 5'd15, 32'hF060_0000);
        add_entry(encode_r(5'd9, 5'd6, 5'd16, 5'd0, `FN_SRAV), 1'b1, 5'd16, 32'hFFFF_F2F4);
        // arithmetic and compares of -16 against 5
        add_entry(encode_i(`OP_ADDIU, 5'd0, 5'd17, 16'hFFF0), 1'b1, 5'd17, 32'hFFFF_FFF0);
        add_entry(encode_i(`OP_ADDIU, 5'd0, 5'd18, 16'h0005), 1'b1, 5'd18, 32'h0000_0005);
        add_entry(encode_r(5'd17, 5'd18, 5'd19, 5'd0, `FN_ADDU), 1'b1, 5'd19, 32'hFFFF_FFF5);
        add_entry(encode_r(5'd18, 5'd17, 5'd20, 5'd0, `FN_SUBU), 1'b1, 5'd20, 32'h0000_0015);
        add_entry(encode_r(5'd17, 5'd18, 5'd21, 5'd0, `FN_SLT),  1'b1, 5'd21, 32'h0000_0001);
        add_entry(encode_r(5'd17, 5'd18, 5'd22, 5'd0, `FN_SLTU), 1'b1, 5'd22, 32'h0000_0000);
        add_entry(encode_i(`OP_SLTI,  5'd17, 5'd23, 16'h0001), 1'b1, 5'd23, 32'h0000_0001);
        add_entry(encode_i(`OP_SLTIU, 5'd18, 5'd24, 16'hFFFF), 1'b1, 5'd24, 32'h0000_0001);
        add_entry(encode_i(`OP_SLTI,  5'd18, 5'd25, 16'hFFFF), 1'b1, 5'd25, 32'h0000_0000);
        add_entry(encode_i(`OP_ADDIU, 5'd18, 5'd26, 16'h8000), 1'b1, 5'd26, 32'hFFFF_8005);
        add_entry(encode_r(5'd19, 5'd17, 5'd27, 5'd0, `FN_SLT),  1'b1, 5'd27, 32'h0000_0000);
        add_entry(encode_r(5'd17, 5'd19, 5'd28, 5'd0, `FN_SLTU), 1'b1, 5'd28, 32'h0000_0001);
        // signed overflow drops the write so r30 keeps 0x1111
        add_entry(encode_i(`OP_LUI,   5'd0,  5'd29, 16'h7FFF), 1'b1, 5'd29, 32'h7FFF_0000);
        add_entry(encode_i(`OP_ORI,   5'd29, 5'd29, 16'hFFFF), 1'b1, 5'd29, 32'h7FFF_FFFF);
        add_entry(encode_i(`OP_ADDIU, 5'd0,  5'd30, 16'h1111), 1'b1, 5'd30, 32'h0000_1111);
        add_entry(encode_r(5'd29, 5'd29, 5'd30, 5'd0, `FN_ADD),  1'b0, 5'd30, 32'hFFFF_FFFE);
        add_entry(encode_i(`OP_ADDI,  5'd29, 5'd30, 16'h0001), 1'b0, 5'd30, 32'h8000_0000);
        add_entry(encode_r(5'd29, 5'd29, 5'd31, 5'd0, `FN_ADDU), 1'b1, 5'd31, 32'hFFFF_FFFE);
        add_entry(encode_r(5'd31, 5'd29, 5'd30, 5'd0, `FN_SUB),  1'b0, 5'd30, 32'h7FFF_FFFF);
        add_entry(encode_r(5'd30, 5'd0,  5'd25, 5'd0, `FN_OR),   1'b1, 5'd25, 32'h0000_1111);
        // $zero destination and unknown encodings
        add_entry(encode_i(`OP_ORI, 5'd2, 5'd0, 16'hFFFF), 1'b0, 5'd0, 32'h1234_FFFF);
        add_entry(encode_r(5'd0, 5'd2, 5'd24, 5'd0, `FN_XOR),  1'b1, 5'd24, 32'h1234_5678);
        add_entry(encode_r(5'd2, 5'd2, 5'd0,  5'd0, `FN_ADDU), 1'b0, 5'd0,  32'h2468_ACF0);
        add_entry(encode_i(6'b111111, 5'd2, 5'd7, 16'h1234), 1'b0, 5'd7, 32'h0000_0000);
        add_entry(encode_r(5'd2, 5'd2, 5'd8, 5'd0, 6'b111111), 1'b0, 5'd8, 32'h0000_0000);
        add_entry(encode_i(`OP_ADDIU, 5'd0, 5'd21, 16'h0042), 1'b1, 5'd21, 32'h0000_0042);
        add_entry(encode_r(5'd7, 5'd0, 5'd23, 5'd0, `FN_OR),   1'b1, 5'd23, 32'h1234_5678);
        add_entry(encode_r(5'd8, 5'd0, 5'd22, 5'd0, `FN_OR),   1'b1, 5'd22, 32'hE0C0_0000);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before the table was done", cycles);
            abort_run();
        end
    end

    // bound checks on the write-back port
    always @(negedge clk) begin
        if (uut.u_assert.fail_cnt != 0) begin
            $display("an assertion on the write-back port failed at %0t", $time);
            abort_run();
        end
    end

    initial begin
        int gap;

        rst_n_i      = 1'b0;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        load_table();

        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n_i = 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            gap = $unsigned($random(seed)) % 3;   // 0 to 2 idle cycles
            repeat (gap) begin
                @(posedge clk);
                #DRV_DLY;
            end
            inst_i       = tbl_inst[i];
            inst_valid_i = 1'b1;
            @(posedge clk);
            #DRV_DLY;
            inst_valid_i = 1'b0;
            inst_i       = '0;
            // write-back comes out one cycle after issue
            compare("wb_we_o", {31'd0, tbl_we[i]}, {31'd0, wb_we_o});
            compare("wb_addr_o", {27'd0, tbl_addr[i]}, {27'd0, wb_addr_o});
            if (tbl_we[i])
                compare("wb_data_o", tbl_data[i], wb_data_o);
        end

        @(posedge clk);
        #DRV_DLY;
        // the last write-back is sampled by the assertions on this edge
        if (uut.u_assert.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("an assertion on the write-back port failed at %0t", $time);
            abort_run();
        end
    end

endmodule

/* flist.f */
+incdir+common
common/pipe_pkg.sv
hw/decode/reg_file.sv
hw/decode/id_stage.sv
hw/id_ex_reg.sv
hw/execute/ex_stage.sv
hw/int_pipe_top.sv
dv/int_pipe_assertions.sv
dv/int_pipe_tb.sv

/* hw/decode/id_stage.sv */
// instruction decode stage
`timescale 1ns/10ps
`include "pipe_consts.svh"

module id_stage (
    input  pipe_pkg::word_t     inst_i,
    input  logic                inst_valid_i,
    input  pipe_pkg::word_t     rdata1_i,
    input  pipe_pkg::word_t     rdata2_i,
    input  pipe_pkg::reg_addr_t ex_wd_i,
    input  logic                ex_wreg_i,
    input  pipe_pkg::word_t     ex_wdata_i,
    output pipe_pkg::reg_addr_t raddr1_o,
    output pipe_pkg::reg_addr_t raddr2_o,
    output pipe_pkg::alu_op_e   aluop_o,
    output pipe_pkg::alu_sel_e  alusel_o,
    output pipe_pkg::word_t     reg1_o,
    output pipe_pkg::word_t     reg2_o,
    output pipe_pkg::reg_addr_t wd_o,
    output logic                wreg_o
);

    logic [`OP_W-1:0]    op;
    logic [`FN_W-1:0]    funct;
    logic [`SHAMT_W-1:0] shamt;
    logic [`IMM_W-1:0]   imm;
    pipe_pkg::reg_addr_t rs;
    pipe_pkg::reg_addr_t rt;
    pipe_pkg::reg_addr_t rd;
    logic                is_special;
    logic                use_shamt;
    logic                imm_sext;
    logic                fwd1;
    logic                fwd2;
    pipe_pkg::word_t     src1;
    pipe_pkg::word_t     src2;
    pipe_pkg::word_t     imm_ext;

    assign op    = inst_i[`F_OP];
    assign funct = inst_i[`F_FUNCT];
    assign shamt = inst_i[`F_SHAMT];
    assign imm   = inst_i[`F_IMM];
    assign rs    = inst_i[`F_RS];
    assign rt    = inst_i[`F_RT];
    assign rd    = inst_i[`F_RD];

    assign raddr1_o = rs;
    assign raddr2_o = rt;

    // bypass the result still sitting in execute
    assign fwd1 = ex_wreg_i && (ex_wd_i != '0) && (ex_wd_i == rs);
    assign fwd2 = ex_wreg_i && (ex_wd_i != '0) && (ex_wd_i == rt);
    assign src1 = fwd1 ? ex_wdata_i : rdata1_i;
    assign src2 = fwd2 ? ex_wdata_i : rdata2_i;

    assign is_special = (op == `OP_SPECIAL);
    assign use_shamt  = is_special &&
                        (funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA);
    assign imm_sext   = (op == `OP_ADDI) || (op == `OP_ADDIU) ||
                        (op == `OP_SLTI) || (op == `OP_SLTIU);
    assign imm_ext    = imm_sext ? {{(`WORD_W-`IMM_W){imm[`IMM_W-1]}}, imm}
                                 : {{(`WORD_W-`IMM_W){1'b0}}, imm};

    // operation from opcode and funct, nop for anything unknown
    always_comb begin
        aluop_o = pipe_pkg::alu_nop;
        if (is_special) begin
            case (funct)
                `FN_AND:  aluop_o = pipe_pkg::alu_and;
                `FN_OR:   aluop_o = pipe_pkg::alu_or;
                `FN_XOR:  aluop_o = pipe_pkg::alu_xor;
                `FN_NOR:  aluop_o = pipe_pkg::alu_nor;
                `FN_SLL,
                `FN_SLLV: aluop_o = pipe_pkg::alu_sll;
                `FN_SRL,
                `FN_SRLV: aluop_o = pipe_pkg::alu_srl;
                `FN_SRA,
                `FN_SRAV: aluop_o = pipe_pkg::alu_sra;
                `FN_ADD:  aluop_o = pipe_pkg::alu_add;
                `FN_ADDU: aluop_o = pipe_pkg::alu_addu;
                `FN_SUB:  aluop_o = pipe_pkg::alu_sub;
                `FN_SUBU: aluop_o = pipe_pkg::alu_subu;
                `FN_SLT:  aluop_o = pipe_pkg::alu_slt;
                `FN_SLTU: aluop_o = pipe_pkg::alu_sltu;
                default:  aluop_o = pipe_pkg::alu_nop;
            endcase
        end else begin
            case (op)
                `OP_ORI:   aluop_o = pipe_pkg::alu_or;
                `OP_ANDI:  aluop_o = pipe_pkg::alu_and;
                `OP_XORI:  aluop_o = pipe_pkg::alu_xor;
                `OP_LUI:   aluop_o = pipe_pkg::alu_lui;
                `OP_ADDI:  aluop_o = pipe_pkg::alu_add;
                `OP_ADDIU: aluop_o = pipe_pkg::alu_addu;
                `OP_SLTI:  aluop_o = pipe_pkg::alu_slt;
                `OP_SLTIU: aluop_o = pipe_pkg::alu_sltu;
                default:   aluop_o = pipe_pkg::alu_nop;
            endcase
        end
    end

    // result group follows the operation
    always_comb begin
        case (aluop_o)
            pipe_pkg::alu_or, pipe_pkg::alu_and, pipe_pkg::alu_xor,
            pipe_pkg::alu_nor, pipe_pkg::alu_lui:
                alusel_o = pipe_pkg::sel_logic;
            pipe_pkg::alu_sll, pipe_pkg::alu_srl, pipe_pkg::alu_sra:
                alusel_o = pipe_pkg::sel_shift;
            pipe_pkg::alu_nop:
                alusel_o = pipe_pkg::sel_none;
            default:
                alusel_o = pipe_pkg::sel_arith;
        endcase
    end

    // shift amount goes in reg1, shifted value in reg2
    assign reg1_o = use_shamt ? {{(`WORD_W-`SHAMT_W){1'b0}}, shamt} : src1;
    assign reg2_o = is_special ? src2 : imm_ext;
    assign wd_o   = is_special ? rd : rt;
    assign wreg_o = inst_valid_i && (aluop_o != pipe_pkg::alu_nop) && (wd_o != '0);

endmodule

/* hw/decode/reg_file.sv */
// general purpose register file
`timescale 1ns/10ps
`include "pipe_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  pipe_pkg::reg_addr_t waddr_i,
    input  pipe_pkg::word_t     wdata_i,
    input  pipe_pkg::reg_addr_t raddr1_i,
    input  pipe_pkg::reg_addr_t raddr2_i,
    output pipe_pkg::word_t     rdata1_o,
    output pipe_pkg::word_t     rdata2_o
);

    pipe_pkg::word_t regs [`REG_NUM];

    logic wr_ok;

    assign wr_ok = we_i && (waddr_i != '0);   // $zero is never written

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write shows up on the read port
    always_comb begin
        if (raddr1_i == '0)
            rdata1_o = '0;
        else if (wr_ok && (waddr_i == raddr1_i))
            rdata1_o = wdata_i;
        else
            rdata1_o = regs[raddr1_i];
    end

    always_comb begin
        if (raddr2_i == '0)
            rdata2_o = '0;
        else if (wr_ok && (waddr_i == raddr2_i))
            rdata2_o = wdata_i;
        else
            rdata2_o = regs[raddr2_i];
    end

endmodule

/* hw/execute/ex_stage.sv */
// execute stage alu
`timescale 1ns/10ps
`include "pipe_consts.svh"

module ex_stage (
    input  pipe_pkg::alu_op_e   aluop_i,
    input  pipe_pkg::alu_sel_e  alusel_i,
    input  pipe_pkg::word_t     reg1_i,
    input  pipe_pkg::word_t     reg2_i,
    input  pipe_pkg::reg_addr_t wd_i,
    input  logic                wreg_i,
    output pipe_pkg::reg_addr_t wd_o,
    output logic                wreg_o,
    output pipe_pkg::word_t     wdata_o
);

    localparam int MSB = `WORD_W - 1;

    pipe_pkg::word_t     logic_res;
    pipe_pkg::word_t     shift_res;
    pipe_pkg::word_t     arith_res;
    pipe_pkg::word_t     reg2_mux;
    pipe_pkg::word_t     sum;
    logic [`SHAMT_W-1:0] sa;
    logic                is_sub;
    logic                ov_sum;
    logic                lt_signed;
    logic                lt_unsigned;
    logic                trap_op;

    // subtract and signed compare add the two's complement
    assign is_sub   = (aluop_i == pipe_pkg::alu_sub) || (aluop_i == pipe_pkg::alu_subu) ||
                      (aluop_i == pipe_pkg::alu_slt);
    assign reg2_mux = is_sub ? (~reg2_i) + 1'b1 : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    assign ov_sum = (!reg1_i[MSB] && !reg2_mux[MSB] && sum[MSB]) ||
                    (reg1_i[MSB] && reg2_mux[MSB] && !sum[MSB]);

    // negative vs positive decides it, otherwise the difference sign does
    assign lt_signed   = (reg1_i[MSB] && !reg2_i[MSB]) ||
                         ((reg1_i[MSB] == reg2_i[MSB]) && sum[MSB]);
    assign lt_unsigned = (reg1_i < reg2_i);

    assign sa = reg1_i[`SHAMT_W-1:0];   // low bits only for variable shifts

    always_comb begin
        case (aluop_i)
            pipe_pkg::alu_or:  logic_res = reg1_i | reg2_i;
            pipe_pkg::alu_and: logic_res = reg1_i & reg2_i;
            pipe_pkg::alu_xor: logic_res = reg1_i ^ reg2_i;
            pipe_pkg::alu_nor: logic_res = ~(reg1_i | reg2_i);
            pipe_pkg::alu_lui: logic_res = {reg2_i[`IMM_W-1:0], {(`WORD_W-`IMM_W){1'b0}}};
            default:           logic_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            pipe_pkg::alu_sll: shift_res = reg2_i << sa;
            pipe_pkg::alu_srl: shift_res = reg2_i >> sa;
            pipe_pkg::alu_sra: shift_res = $signed(reg2_i) >>> sa;   // sign fill
            default:           shift_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            pipe_pkg::alu_add,
            pipe_pkg::alu_addu,
            pipe_pkg::alu_sub,
            pipe_pkg::alu_subu: arith_res = sum;
            pipe_pkg::alu_slt:  arith_res = {{MSB{1'b0}}, lt_signed};
            pipe_pkg::alu_sltu: arith_res = {{MSB{1'b0}}, lt_unsigned};
            default:            arith_res = '0;
        endcase
    end

    // only the trapping forms drop their write
    assign trap_op = (aluop_i == pipe_pkg::alu_add) || (aluop_i == pipe_pkg::alu_sub);

    assign wd_o   = wd_i;
    assign wreg_o = wreg_i && !(trap_op && ov_sum);

    always_comb begin
        case (alusel_i)
            pipe_pkg::sel_logic: wdata_o = logic_res;
            pipe_pkg::sel_shift: wdata_o = shift_res;
            pipe_pkg::sel_arith: wdata_o = arith_res;
            default:             wdata_o = '0;
        endcase
    end

endmodule

/* hw/id_ex_reg.sv */
// decode to execute pipeline register
`timescale 1ns/10ps

module id_ex_reg (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  pipe_pkg::alu_op_e   aluop_i,
    input  pipe_pkg::alu_sel_e  alusel_i,
    input  pipe_pkg::word_t     reg1_i,
    input  pipe_pkg::word_t     reg2_i,
    input  pipe_pkg::reg_addr_t wd_i,
    input  logic                wreg_i,
    output pipe_pkg::alu_op_e   aluop_o,
    output pipe_pkg::alu_sel_e  alusel_o,
    output pipe_pkg::word_t     reg1_o,
    output pipe_pkg::word_t     reg2_o,
    output pipe_pkg::reg_addr_t wd_o,
    output logic                wreg_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i || !valid_i) begin
            // bubble, nothing gets written back
            aluop_o  <= pipe_pkg::alu_nop;
            alusel_o <= pipe_pkg::sel_none;
            reg1_o   <= '0;
            reg2_o   <= '0;
            wd_o     <= '0;
            wreg_o   <= 1'b0;
        end else begin
            aluop_o  <= aluop_i;
            alusel_o <= alusel_i;
            reg1_o   <= reg1_i;
            reg2_o   <= reg2_i;
            wd_o     <= wd_i;
            wreg_o   <= wreg_i;
        end
    end

endmodule

/* hw/int_pipe_top.sv */
// integer pipeline top level
`timescale 1ns/10ps

module int_pipe_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  pipe_pkg::word_t     inst_i,
    input  logic                inst_valid_i,
    output logic                wb_we_o,
    output pipe_pkg::reg_addr_t wb_addr_o,
    output pipe_pkg::word_t     wb_data_o
);

    // decode side
    pipe_pkg::reg_addr_t raddr1;
    pipe_pkg::reg_addr_t raddr2;
    pipe_pkg::word_t     rdata1;
    pipe_pkg::word_t     rdata2;
    pipe_pkg::alu_op_e   id_aluop;
    pipe_pkg::alu_sel_e  id_alusel;
    pipe_pkg::word_t     id_reg1;
    pipe_pkg::word_t     id_reg2;
    pipe_pkg::reg_addr_t id_wd;
    logic                id_wreg;

    // execute side
    pipe_pkg::alu_op_e   ex_aluop;
    pipe_pkg::alu_sel_e  ex_alusel;
    pipe_pkg::word_t     ex_reg1;
    pipe_pkg::word_t     ex_reg2;
    pipe_pkg::reg_addr_t ex_wd_in;
    logic                ex_wreg_in;
    pipe_pkg::reg_addr_t ex_wd;
    logic                ex_wreg;
    pipe_pkg::word_t     ex_wdata;

    id_stage u_id (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_wd_i      (ex_wd),
        .ex_wreg_i    (ex_wreg),
        .ex_wdata_i   (ex_wdata),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .aluop_o      (id_aluop),
        .alusel_o     (id_alusel),
        .reg1_o       (id_reg1),
        .reg2_o       (id_reg2),
        .wd_o         (id_wd),
        .wreg_o       (id_wreg)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (ex_wreg),
        .waddr_i  (ex_wd),
        .wdata_i  (ex_wdata),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    id_ex_reg u_id_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (inst_valid_i),
        .aluop_i  (id_aluop),
        .alusel_i (id_alusel),
        .reg1_i   (id_reg1),
        .reg2_i   (id_reg2),
        .wd_i     (id_wd),
        .wreg_i   (id_wreg),
        .aluop_o  (ex_aluop),
        .alusel_o (ex_alusel),
        .reg1_o   (ex_reg1),
        .reg2_o   (ex_reg2),
        .wd_o     (ex_wd_in),
        .wreg_o   (ex_wreg_in)
    );

    ex_stage u_ex (
        .aluop_i  (ex_aluop),
        .alusel_i (ex_alusel),
        .reg1_i   (ex_reg1),
        .reg2_i   (ex_reg2),
        .wd_i     (ex_wd_in),
        .wreg_i   (ex_wreg_in),
        .wd_o     (ex_wd),
        .wreg_o   (ex_wreg),
        .wdata_o  (ex_wdata)
    );

    // write-back port mirrors the register file write
    assign wb_we_o   = ex_wreg;
    assign wb_addr_o = ex_wd;
    assign wb_data_o = ex_wdata;

endmodule
